// ==== axil_mem_sub.f ====
+incdir+include
rtl/axil_pkg.sv
rtl/axil_if.sv
rtl/access_timer.sv
rtl/axil_arbiter.sv
rtl/sram_slave.sv
rtl/axil_mem_sub.sv
test/axil_asserts.sv
test/tb_axil_mem_sub.sv

// ==== include/axil_params.svh ====
`ifndef AXIL_PARAMS_SVH
`define AXIL_PARAMS_SVH

// bus widths
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32

// sram depth in words, byte addresses 0 to 1023
`define AXIL_MEM_WORDS 256

// cycles from accepted request to response valid, at least 1
`define AXIL_LATENCY 3

`endif

// ==== rtl/access_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "axil_params.svh"

module access_timer (
	input wire logic clk,
	input wire logic rst,
	input wire logic start,
	output logic busy,
	output logic done
);

	localparam int CNT_W = $clog2(`AXIL_LATENCY + 1);
	localparam logic [CNT_W-1:0] LOAD = CNT_W'(`AXIL_LATENCY);

	logic [CNT_W-1:0] count;

	// start reloads even if a count is running
	always_ff @(posedge clk) begin
		if (!rst) begin
			count <= '0;
		end else if (start) begin
			count <= LOAD;
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	assign busy = (count != '0);

	// last cycle of the wait, sampled latency edges after start
	assign done = (count == CNT_W'(1));

endmodule

`default_nettype wire

// ==== rtl/axil_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module axil_arbiter import axil_pkg::*; (
	input wire logic clk,
	input wire logic rst,

	// instruction fetch master
	input wire addr_t ifu_araddr,
	input wire logic ifu_arvalid,
	output logic ifu_arready,
	output data_t ifu_rdata,
	output resp_t ifu_rresp,
	output logic ifu_rvalid,
	input wire logic ifu_rready,
	input wire addr_t ifu_awaddr,
	input wire logic ifu_awvalid,
	output logic ifu_awready,
	input wire data_t ifu_wdata,
	input wire strb_t ifu_wstrb,
	input wire logic ifu_wvalid,
	output logic ifu_wready,
	output resp_t ifu_bresp,
	output logic ifu_bvalid,
	input wire logic ifu_bready,

	// load/store master
	input wire addr_t lsu_araddr,
	input wire logic lsu_arvalid,
	output logic lsu_arready,
	output data_t lsu_rdata,
	output resp_t lsu_rresp,
	output logic lsu_rvalid,
	input wire logic lsu_rready,
	input wire addr_t lsu_awaddr,
	input wire logic lsu_awvalid,
	output logic lsu_awready,
	input wire data_t lsu_wdata,
	input wire strb_t lsu_wstrb,
	input wire logic lsu_wvalid,
	output logic lsu_wready,
	output resp_t lsu_bresp,
	output logic lsu_bvalid,
	input wire logic lsu_bready,

	axil_if.master mem
);

	arb_state_t state;
	logic ifu_trigger;
	logic lsu_trigger;
	logic resp_done;
	logic sel_ifu;
	logic sel_lsu;

	// a write needs address and data together
	assign ifu_trigger = ifu_arvalid | (ifu_awvalid & ifu_wvalid);
	assign lsu_trigger = lsu_arvalid | (lsu_awvalid & lsu_wvalid);

	// release only once the granted master took its response
	assign resp_done = (mem.rvalid & mem.rready) | (mem.bvalid & mem.bready);

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= arb_idle;
		end else begin
			case (state)
				arb_idle: begin
					if (ifu_trigger) begin
						state <= serve_ifu;
					end else if (lsu_trigger) begin
						state <= serve_lsu;
					end
				end
				serve_ifu, serve_lsu: begin
					if (resp_done) begin
						state <= arb_idle;
					end
				end
				default: begin
					state <= arb_idle;
				end
			endcase
		end
	end

	assign sel_ifu = (state == serve_ifu);
	assign sel_lsu = (state == serve_lsu);

	// request side toward the slave
	always_comb begin
		mem.araddr = '0;
		mem.arvalid = 1'b0;
		mem.rready = 1'b0;
		mem.awaddr = '0;
		mem.awvalid = 1'b0;
		mem.wdata = '0;
		mem.wstrb = '0;
		mem.wvalid = 1'b0;
		mem.bready = 1'b0;
		if (sel_ifu) begin
			mem.araddr = ifu_araddr;
			mem.arvalid = ifu_arvalid;
			mem.rready = ifu_rready;
			mem.awaddr = ifu_awaddr;
			mem.awvalid = ifu_awvalid;
			mem.wdata = ifu_wdata;
			mem.wstrb = ifu_wstrb;
			mem.wvalid = ifu_wvalid;
			mem.bready = ifu_bready;
		end else if (sel_lsu) begin
			mem.araddr = lsu_araddr;
			mem.arvalid = lsu_arvalid;
			mem.rready = lsu_rready;
			mem.awaddr = lsu_awaddr;
			mem.awvalid = lsu_awvalid;
			mem.wdata = lsu_wdata;
			mem.wstrb = lsu_wstrb;
			mem.wvalid = lsu_wvalid;
			mem.bready = lsu_bready;
		end
	end

	// response side, masked toward the master without the grant
	assign ifu_arready = sel_ifu & mem.arready;
	assign ifu_awready = sel_ifu & mem.awready;
	assign ifu_wready = sel_ifu & mem.wready;
	assign ifu_rvalid = sel_ifu & mem.rvalid;
	assign ifu_bvalid = sel_ifu & mem.bvalid;
	assign ifu_rdata = sel_ifu ? mem.rdata : '0;
	assign ifu_rresp = sel_ifu ? mem.rresp : RESP_OKAY;
	assign ifu_bresp = sel_ifu ? mem.bresp : RESP_OKAY;

	assign lsu_arready = sel_lsu & mem.arready;
	assign lsu_awready = sel_lsu & mem.awready;
	assign lsu_wready = sel_lsu & mem.wready;
	assign lsu_rvalid = sel_lsu & mem.rvalid;
	assign lsu_bvalid = sel_lsu & mem.bvalid;
	assign lsu_rdata = sel_lsu ? mem.rdata : '0;
	assign lsu_rresp = sel_lsu ? mem.rresp : RESP_OKAY;
	assign lsu_bresp = sel_lsu ? mem.bresp : RESP_OKAY;

endmodule

`default_nettype wire

// ==== rtl/axil_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface axil_if import axil_pkg::*; ();

	// read address
	addr_t araddr;
	logic arvalid;
	logic arready;

	// read data
	data_t rdata;
	resp_t rresp;
	logic rvalid;
	logic rready;

	// write address
	addr_t awaddr;
	logic awvalid;
	logic awready;

	// write data
	data_t wdata;
	strb_t wstrb;
	logic wvalid;
	logic wready;

	// write response
	resp_t bresp;
	logic bvalid;
	logic bready;

	modport master (
		output araddr, arvalid, rready,
		output awaddr, awvalid,
		output wdata, wstrb, wvalid,
		output bready,
		input arready, rdata, rresp, rvalid,
		input awready, wready, bresp, bvalid
	);

	modport slave (
		input araddr, arvalid, rready,
		input awaddr, awvalid,
		input wdata, wstrb, wvalid,
		input bready,
		output arready, rdata, rresp, rvalid,
		output awready, wready, bresp, bvalid
	);

endinterface

`default_nettype wire

// ==== rtl/axil_mem_sub.sv ====
`timescale 1ns/1ns
`default_nettype none

module axil_mem_sub import axil_pkg::*; (
	input wire logic clk,
	input wire logic rst,

	// instruction fetch port
	input wire addr_t ifu_araddr,
	input wire logic ifu_arvalid,
	output logic ifu_arready,
	output data_t ifu_rdata,
	output resp_t ifu_rresp,
	output logic ifu_rvalid,
	input wire logic ifu_rready,
	input wire addr_t ifu_awaddr,
	input wire logic ifu_awvalid,
	output logic ifu_awready,
	input wire data_t ifu_wdata,
	input wire strb_t ifu_wstrb,
	input wire logic ifu_wvalid,
	output logic ifu_wready,
	output resp_t ifu_bresp,
	output logic ifu_bvalid,
	input wire logic ifu_bready,

	// load/store port
	input wire addr_t lsu_araddr,
	input wire logic lsu_arvalid,
	output logic lsu_arready,
	output data_t lsu_rdata,
	output resp_t lsu_rresp,
	output logic lsu_rvalid,
	input wire logic lsu_rready,
	input wire addr_t lsu_awaddr,
	input wire logic lsu_awvalid,
	output logic lsu_awready,
	input wire data_t lsu_wdata,
	input wire strb_t lsu_wstrb,
	input wire logic lsu_wvalid,
	output logic lsu_wready,
	output resp_t lsu_bresp,
	output logic lsu_bvalid,
	input wire logic lsu_bready
);

	// single downstream channel to the sram
	axil_if mem_bus ();

	// master ports share their names with the top level
	axil_arbiter u_arbiter (
		.*,
		.mem(mem_bus)
	);

	sram_slave u_sram (
		.clk(clk),
		.rst(rst),
		.bus(mem_bus)
	);

endmodule

`default_nettype wire

// ==== rtl/axil_pkg.sv ====
`default_nettype none

`include "axil_params.svh"

package axil_pkg;

	typedef logic [`AXIL_ADDR_W-1:0] addr_t;
	typedef logic [`AXIL_DATA_W-1:0] data_t;
	typedef logic [`AXIL_DATA_W/8-1:0] strb_t;
	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

	// grant owner of the downstream port
	typedef enum logic [1:0] {
		arb_idle,
		serve_ifu,
		serve_lsu
	} arb_state_t;

	// slave channel sequencing
	typedef enum logic [1:0] {
		mem_idle,
		busy,
		resp_r,
		resp_b
	} mem_state_t;

endpackage

`default_nettype wire

// ==== rtl/sram_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "axil_params.svh"

module sram_slave import axil_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	axil_if.slave bus
);

	localparam int IDX_W = $clog2(`AXIL_MEM_WORDS);
	localparam int STRB_W = `AXIL_DATA_W / 8;

	mem_state_t state;
	data_t mem [0:`AXIL_MEM_WORDS-1];

	addr_t addr_q;
	data_t wdata_q;
	strb_t wstrb_q;
	logic is_wr_q;
	data_t rdata_q;
	resp_t resp_q;

	logic rd_go;
	logic wr_go;
	logic timer_busy;
	logic done;
	logic in_range;
	logic [IDX_W-1:0] idx;

	// read wins when both arrive together
	assign bus.arready = (state == mem_idle) & ~timer_busy;
	assign bus.awready = bus.arready & bus.awvalid & bus.wvalid & ~bus.arvalid;
	assign bus.wready = bus.awready;

	assign rd_go = bus.arvalid & bus.arready;
	assign wr_go = bus.awvalid & bus.awready & bus.wvalid & bus.wready;

	access_timer u_timer (
		.clk(clk),
		.rst(rst),
		.start(rd_go | wr_go),
		.busy(timer_busy),
		.done(done)
	);

	// bits above the word index must be clear
	assign in_range = (addr_q[`AXIL_ADDR_W-1:IDX_W+2] == '0);
	assign idx = addr_q[IDX_W+1:2];

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= mem_idle;
			is_wr_q <= 1'b0;
		end else begin
			case (state)
				mem_idle: begin
					if (rd_go) begin
						state <= busy;
						is_wr_q <= 1'b0;
					end else if (wr_go) begin
						state <= busy;
						is_wr_q <= 1'b1;
					end
				end
				busy: begin
					if (done) begin
						state <= is_wr_q ? resp_b : resp_r;
					end
				end
				resp_r: begin
					if (bus.rready) begin
						state <= mem_idle;
					end
				end
				resp_b: begin
					if (bus.bready) begin
						state <= mem_idle;
					end
				end
				default: begin
					state <= mem_idle;
				end
			endcase
		end
	end

	// request capture
	always_ff @(posedge clk) begin
		if (rd_go) begin
			addr_q <= bus.araddr;
		end else if (wr_go) begin
			addr_q <= bus.awaddr;
			wdata_q <= bus.wdata;
			wstrb_q <= bus.wstrb;
		end
	end

	// memory access and response payload at the end of the wait
	always_ff @(posedge clk) begin
		if (state == busy && done) begin
			resp_q <= in_range ? RESP_OKAY : RESP_SLVERR;
			if (is_wr_q) begin
				if (in_range) begin
					for (int i = 0; i < STRB_W; i++) begin
						if (wstrb_q[i]) begin
							mem[idx][8*i +: 8] <= wdata_q[8*i +: 8];
						end
					end
				end
			end else begin
				rdata_q <= in_range ? mem[idx] : '0;
			end
		end
	end

	// payloads stay put while the master stalls
	assign bus.rvalid = (state == resp_r);
	assign bus.rdata = rdata_q;
	assign bus.rresp = resp_q;
	assign bus.bvalid = (state == resp_b);
	assign bus.bresp = resp_q;

endmodule

`default_nettype wire

// ==== test/axil_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module axil_asserts import axil_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic [1:0] state,
	input wire logic ifu_rvalid, ifu_bvalid, lsu_rvalid, lsu_bvalid,
	input wire logic mem_arvalid, mem_awvalid, mem_wvalid,
	input wire logic mem_rvalid, mem_rready, mem_bvalid, mem_bready,
	input wire data_t mem_rdata
);

	logic resp_done;

	// failed assertions so far
	int error_count = 0;

	assign resp_done = (mem_rvalid & mem_rready) | (mem_bvalid & mem_bready);

	one_owner: assert property (@(posedge clk) disable iff (!rst)
		$onehot0({ifu_rvalid, ifu_bvalid, lsu_rvalid, lsu_bvalid}))
		else begin
			$error("more than one response valid toward the masters");
			error_count++;
		end

	// grant only ends on a response handshake
	grant_held: assert property (@(posedge clk) disable iff (!rst)
		(state != arb_idle && !resp_done) |=> state == $past(state))
		else begin
			$error("grant changed without a response handshake");
			error_count++;
		end

	rdata_held: assert property (@(posedge clk) disable iff (!rst)
		(mem_rvalid && !mem_rready) |=> mem_rvalid && $stable(mem_rdata))
		else begin
			$error("read response dropped or changed while stalled");
			error_count++;
		end

	idle_quiet: assert property (@(posedge clk) disable iff (!rst)
		state == arb_idle |->
			!(mem_arvalid || mem_awvalid || mem_wvalid || mem_rvalid || mem_bvalid))
		else begin
			$error("downstream valid high with no grant");
			error_count++;
		end

endmodule

bind axil_arbiter axil_asserts u_asserts (
	.clk(clk), .rst(rst), .state(state),
	.ifu_rvalid(ifu_rvalid), .ifu_bvalid(ifu_bvalid),
	.lsu_rvalid(lsu_rvalid), .lsu_bvalid(lsu_bvalid),
	.mem_arvalid(mem.arvalid), .mem_awvalid(mem.awvalid), .mem_wvalid(mem.wvalid),
	.mem_rvalid(mem.rvalid), .mem_rready(mem.rready),
	.mem_bvalid(mem.bvalid), .mem_bready(mem.bready),
	.mem_rdata(mem.rdata)
);

`default_nettype wire

// ==== test/tb_axil_mem_sub.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "axil_params.svh"

module tb_axil_mem_sub import axil_pkg::*; ();

	localparam int MAX_STALL = 7;
	localparam int N_TX = `AXIL_MEM_WORDS + 12 + 16 + 5 + 9 + 9 + 80;
	localparam int TIMEOUT = N_TX * (2 + `AXIL_LATENCY + MAX_STALL) + 200;

	logic clk;
	logic rst;

	// index 0 is the ifu, index 1 the lsu
	addr_t [1:0] araddr, awaddr;
	data_t [1:0] wdata;
	strb_t [1:0] wstrb;
	logic [1:0] arvalid, awvalid, wvalid, rready, bready;
	wire [1:0] arready, awready, wready, rvalid, bvalid;
	wire [1:0][`AXIL_DATA_W-1:0] rdata;
	wire [1:0][1:0] rresp, bresp;

	logic [7:0] ref_mem [0:4*`AXIL_MEM_WORDS-1];
	logic [31:0] rng = 32'h255c3191;
	int cycles = 0;
	time seen_at [2];
	time done_at [2];

	axil_mem_sub u_dut (
		.clk(clk),
		.rst(rst),
		.ifu_araddr(araddr[0]), .ifu_arvalid(arvalid[0]), .ifu_arready(arready[0]),
		.ifu_rdata(rdata[0]), .ifu_rresp(rresp[0]), .ifu_rvalid(rvalid[0]),
		.ifu_rready(rready[0]), .ifu_awaddr(awaddr[0]), .ifu_awvalid(awvalid[0]),
		.ifu_awready(awready[0]), .ifu_wdata(wdata[0]), .ifu_wstrb(wstrb[0]),
		.ifu_wvalid(wvalid[0]), .ifu_wready(wready[0]), .ifu_bresp(bresp[0]),
		.ifu_bvalid(bvalid[0]), .ifu_bready(bready[0]),
		.lsu_araddr(araddr[1]), .lsu_arvalid(arvalid[1]), .lsu_arready(arready[1]),
		.lsu_rdata(rdata[1]), .lsu_rresp(rresp[1]), .lsu_rvalid(rvalid[1]),
		.lsu_rready(rready[1]), .lsu_awaddr(awaddr[1]), .lsu_awvalid(awvalid[1]),
		.lsu_awready(awready[1]), .lsu_wdata(wdata[1]), .lsu_wstrb(wstrb[1]),
		.lsu_wvalid(wvalid[1]), .lsu_wready(wready[1]), .lsu_bresp(bresp[1]),
		.lsu_bvalid(bvalid[1]), .lsu_bready(bready[1])
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("timeout: the tests did not finish within %0d cycles", TIMEOUT);
			$display("RESULT: FAIL");
			$fatal(1, "simulation timed out");
		end
	end

	// failures of the bound arbiter assertions
	always @(negedge clk) begin
		if (u_dut.u_arbiter.u_asserts.error_count != 0) begin
			$display("an arbiter assertion failed at t=%0t", $time);
			$display("RESULT: FAIL");
			$fatal(1, "assertion failed");
		end
	end

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// only the low 1 KiB is mapped
	function automatic resp_t resp_for(input addr_t a);
		return (a < 4 * `AXIL_MEM_WORDS) ? RESP_OKAY : RESP_SLVERR;
	endfunction

	function automatic data_t ref_word(input addr_t a);
		data_t w;
		for (int i = 0; i < 4; i++) begin
			w[8*i +: 8] = ref_mem[int'(a[9:2]) * 4 + i];
		end
		return w;
	endfunction

	function automatic void ref_store(input addr_t a, input data_t d, input strb_t s);
		for (int i = 0; i < 4; i++) begin
			if (s[i]) begin
				ref_mem[int'(a[9:2]) * 4 + i] = d[8*i +: 8];
			end
		end
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// one read or write by master m with the response held off for stall cycles
	task automatic access(input int m, input bit is_rd, input addr_t a, input data_t d,
			input strb_t s, input int stall);
		data_t held;
		string who;
		who = (m != 0) ? "lsu_" : "ifu_";
		@(posedge clk);
		if (is_rd) begin
			araddr[m] <= a;
			arvalid[m] <= 1'b1;
		end else begin
			awaddr[m] <= a;
			wdata[m] <= d;
			wstrb[m] <= s;
			awvalid[m] <= 1'b1;
			wvalid[m] <= 1'b1;
		end
		do begin
			@(negedge clk);
		end while (!(is_rd ? arready[m] : awready[m] & wready[m]));
		@(posedge clk);
		arvalid[m] <= 1'b0;
		awvalid[m] <= 1'b0;
		wvalid[m] <= 1'b0;
		do begin
			@(negedge clk);
		end while (!(is_rd ? rvalid[m] : bvalid[m]));
		seen_at[m] = $time;
		check_value({who, is_rd ? "rresp" : "bresp"}, is_rd ? rresp[m] : bresp[m],
			resp_for(a));
		if (is_rd && resp_for(a) == RESP_OKAY) begin
			check_value({who, "rdata"}, rdata[m], ref_word(a));
		end else if (!is_rd && resp_for(a) == RESP_OKAY) begin
			ref_store(a, d, s);
		end
		held = is_rd ? rdata[m] : data_t'(bresp[m]);
		repeat (stall) begin
			@(negedge clk);
			check_value({who, "resp_valid"}, is_rd ? rvalid[m] : bvalid[m], 1);
			check_value({who, is_rd ? "rdata" : "bresp"},
				is_rd ? rdata[m] : data_t'(bresp[m]), held);
		end
		@(posedge clk);
		rready[m] <= is_rd;
		bready[m] <= !is_rd;
		@(negedge clk);
		check_value({who, "resp_valid"}, is_rd ? rvalid[m] : bvalid[m], 1);
		@(posedge clk);
		rready[m] <= 1'b0;
		bready[m] <= 1'b0;
		done_at[m] = $time;
	endtask

	task automatic fill_memory();
		addr_t a;
		for (int w = 0; w < `AXIL_MEM_WORDS; w++) begin
			a = addr_t'(w * 4);
			access(1, 1'b0, a, {~a[15:0], a[15:0]}, 4'hf, 0);
		end
	endtask

	task automatic strobe_readback();
		strb_t s;
		for (int i = 0; i < 6; i++) begin
			s = (i == 0) ? 4'hf : strb_t'(next_rand());
			access(0, 1'b0, addr_t'(32'h40 + 4 * i), next_rand(), s, 0);
		end
		for (int i = 0; i < 6; i++) begin
			access(0, 1'b1, addr_t'(32'h40 + 4 * i), '0, '0, 0);
		end
	endtask

	task automatic shared_memory();
		for (int i = 0; i < 4; i++) begin
			access(1, 1'b0, addr_t'(32'h100 + 4 * i), next_rand(), 4'hf, 0);
			access(0, 1'b1, addr_t'(32'h100 + 4 * i), '0, '0, 0);
			access(0, 1'b0, addr_t'(32'h100 + 4 * i), next_rand(), 4'h6, 0);
			access(1, 1'b1, addr_t'(32'h100 + 4 * i), '0, '0, 0);
		end
	endtask

	task automatic same_edge();
		data_t d;
		for (int i = 0; i < 2; i++) begin
			d = next_rand();
			fork
				access(0, i == 1, addr_t'(32'h200), d, 4'hf, 0);
				access(1, i == 0, addr_t'(32'h200), d ^ 32'hffff, 4'h3, 0);
			join
			// lsu response only after the ifu is done
			check_value("lsu_after_ifu", seen_at[1] > done_at[0], 1);
		end
		access(1, 1'b1, addr_t'(32'h200), '0, '0, 0);
	endtask

	task automatic response_stall();
		int st;
		for (int i = 0; i < 4; i++) begin
			st = 1 + int'(next_rand() % MAX_STALL);
			access(i % 2, 1'b0, addr_t'(32'h300 + 4 * i), next_rand(), 4'hf, st);
			st = 1 + int'(next_rand() % MAX_STALL);
			access(i % 2, 1'b1, addr_t'(32'h300 + 4 * i), '0, '0, st);
		end
		access(1, 1'b1, addr_t'(32'h300), '0, '0, 0);
	endtask

	task automatic out_of_range();
		addr_t bad;
		for (int i = 0; i < 3; i++) begin
			bad = (i == 2) ? 32'h8000_0010 : addr_t'(32'h400 + 4 * i);
			access(i % 2, 1'b0, bad, next_rand(), 4'hf, 0);
			access(i % 2, 1'b1, bad, '0, '0, 0);
			// aliased word in the map keeps its value
			access(0, 1'b1, bad & 32'h3fc, '0, '0, 0);
		end
	endtask

	task automatic random_mix();
		bit rd [2];
		addr_t a [2];
		data_t d [2];
		strb_t s [2];
		int st [2];
		for (int n = 0; n < 40; n++) begin
			for (int m = 0; m < 2; m++) begin
				rd[m] = bit'(next_rand() & 1);
				a[m] = addr_t'((next_rand() % 16) * 4);
				d[m] = next_rand();
				s[m] = strb_t'(next_rand());
				st[m] = int'(next_rand() % 4);
			end
			fork
				access(0, rd[0], a[0], d[0], s[0], st[0]);
				access(1, rd[1], a[1], d[1], s[1], st[1]);
			join
		end
	endtask

	initial begin
		rst = 1'b0;
		{arvalid, awvalid, wvalid, rready, bready} = '0;
		araddr = '0;
		awaddr = '0;
		wdata = '0;
		wstrb = '0;
		repeat (3) @(posedge clk);
		rst <= 1'b1;
		fill_memory();
		strobe_readback();
		shared_memory();
		same_edge();
		response_stall();
		out_of_range();
		random_mix();
		@(negedge clk);
		if (u_dut.u_arbiter.u_asserts.error_count == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			$display("an arbiter assertion failed before the end of the run");
			$display("RESULT: FAIL");
			$fatal(1, "assertion failed");
		end
	end

endmodule

`default_nettype wire
